/* mini_mips.f */
hdl/mips_core_pkg.sv
hdl/fetch_stage.sv
hdl/inst_decode.sv
hdl/reg_file.sv
hdl/execute.sv
hdl/mini_mips_top.sv
tb/mini_mips_tb.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the mini_mips testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ_DIR=obj_dir
SIM_BIN=sim_mini_mips

verilator --binary --timing -f mini_mips.f --top-module mini_mips_tb \
    --Mdir "$OBJ_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
    echo "Verilator compilation failed"
    exit 1
fi

"./$OBJ_DIR/$SIM_BIN" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "Test failed" "$LOG"; then
    echo "Simulation reported a failure, see $LOG"
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "Simulator exited with status $sim_status"
    exit 1
fi
if ! grep -q "Test passed" "$LOG"; then
    echo "Simulation ended without a result"
    exit 1
fi
exit 0

/* tb/mini_mips_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module mini_mips_tb import mips_core_pkg::*; ();

    localparam int unsigned            INST_ADDR_W  = 32;
    localparam logic [INST_ADDR_W-1:0] RESET_PC     = '0;
    localparam int                     CLK_PERIOD   = 40;
    localparam int                     DRIVE_DELAY  = 2;
    localparam int                     RESET_CYCLES = 4;
    localparam int                     MAX_PROG     = 64;
    localparam logic [31:0]            SEED         = 32'hef4a_a5d2;

    logic                   clk;
    logic                   reset_i;
    word_t                  inst;
    logic [INST_ADDR_W-1:0] inst_addr;
    logic [INST_ADDR_W-1:0] rom_idx;
    reg_write_t             debug_wb;

    word_t       prog_inst [MAX_PROG];
    reg_write_t  prog_exp  [MAX_PROG];
    int          prog_len;
    logic        table_ready;
    word_t       model_regs [NUM_REGS];
    word_t       model_hi;
    word_t       model_lo;
    logic [31:0] rng_state;

    mini_mips_top #(
        .INST_ADDR_W (INST_ADDR_W),
        .RESET_PC    (RESET_PC)
    ) dut0 (
        .clk         (clk),
        .reset_i     (reset_i),
        .inst_i      (inst),
        .inst_addr_o (inst_addr),
        .debug_wb_o  (debug_wb)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // Instruction ROM, nops past the end of the program
    always_comb begin
        rom_idx = (inst_addr - RESET_PC) >> 2;
        if (rom_idx < INST_ADDR_W'(prog_len)) begin
            inst = prog_inst[rom_idx[5:0]];
        end else begin
            inst = ZERO_WORD;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic word_t next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic logic [15:0] rand16();
        word_t w;
        w = next_rand();
        return w[15:0];
    endfunction

    function automatic logic [4:0] rand5();
        word_t w;
        w = next_rand();
        return w[4:0];
    endfunction

    function automatic word_t reg_form(input funct_e fn, input reg_addr_t rs,
                                       input reg_addr_t rt, input reg_addr_t rd);
        return {OP_SPECIAL, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic word_t shamt_form(input funct_e fn, input reg_addr_t rt,
                                         input reg_addr_t rd, input logic [4:0] sa);
        return {OP_SPECIAL, REG_ZERO, rt, rd, sa, fn};
    endfunction

    function automatic word_t imm_form(input opcode_e op, input reg_addr_t rs,
                                       input reg_addr_t rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // Fill from the sign bit
    function automatic word_t shift_right_arith(input word_t v, input logic [4:0] n);
        word_t fill;
        fill = v[31] ? ~(32'hffff_ffff >> n) : ZERO_WORD;
        return (v >> n) | fill;
    endfunction

    function automatic reg_write_t write_to(input reg_addr_t rd, input word_t data);
        reg_write_t w;
        w.we   = (rd != REG_ZERO);
        w.addr = rd;
        w.data = data;
        return w;
    endfunction

    // Reference model step, then append to the table
    task automatic add_inst(input word_t iw);
        inst_t       f;
        logic [15:0] imm;
        word_t       rs_v;
        word_t       rt_v;
        reg_write_t  exp;
        f    = iw;
        imm  = iw[15:0];
        rs_v = model_regs[f.rs];
        rt_v = model_regs[f.rt];
        exp  = '0;
        case (f.opcode)
            OP_ORI:  exp = write_to(f.rt, rs_v | {16'h0000, imm});
            OP_ANDI: exp = write_to(f.rt, rs_v & {16'h0000, imm});
            OP_XORI: exp = write_to(f.rt, rs_v ^ {16'h0000, imm});
            OP_LUI:  exp = write_to(f.rt, rs_v | {imm, 16'h0000});
            OP_SPECIAL: begin
                case (f.funct)
                    F_OR:   exp = write_to(f.rd, rs_v | rt_v);
                    F_AND:  exp = write_to(f.rd, rs_v & rt_v);
                    F_XOR:  exp = write_to(f.rd, rs_v ^ rt_v);
                    F_NOR:  exp = write_to(f.rd, ~(rs_v | rt_v));
                    F_SLLV: exp = write_to(f.rd, rt_v << rs_v[4:0]);
                    F_SRLV: exp = write_to(f.rd, rt_v >> rs_v[4:0]);
                    F_SRAV: exp = write_to(f.rd, shift_right_arith(rt_v, rs_v[4:0]));
                    F_SLL:  exp = write_to(f.rd, rt_v << f.shamt);
                    F_SRL:  exp = write_to(f.rd, rt_v >> f.shamt);
                    F_SRA:  exp = write_to(f.rd, shift_right_arith(rt_v, f.shamt));
                    F_MOVN: begin
                        if (rt_v != ZERO_WORD) begin
                            exp = write_to(f.rd, rs_v);
                        end
                    end
                    F_MOVZ: begin
                        if (rt_v == ZERO_WORD) begin
                            exp = write_to(f.rd, rs_v);
                        end
                    end
                    F_MFHI: exp = write_to(f.rd, model_hi);
                    F_MFLO: exp = write_to(f.rd, model_lo);
                    F_MTHI: model_hi = rs_v;
                    F_MTLO: model_lo = rs_v;
                    default: exp = '0;
                endcase
            end
            default: exp = '0;
        endcase
        if (exp.we) begin
            model_regs[exp.addr] = exp.data;
        end
        if (prog_len >= MAX_PROG) begin
            $display("Program table overflow at entry %0d", prog_len);
            $display("Test failed");
            $fatal(1, "program table too long");
        end
        prog_inst[prog_len] = iw;
        prog_exp[prog_len]  = exp;
        prog_len++;
    endtask

    task automatic build_program();
        word_t     w;
        reg_addr_t r;
        prog_len  = 0;
        rng_state = SEED;
        model_hi  = ZERO_WORD;
        model_lo  = ZERO_WORD;
        for (int i = 0; i < NUM_REGS; i++) begin
            model_regs[i] = ZERO_WORD;
        end
        // Seed r1..r8, r8 negative
        for (int i = 1; i <= 8; i++) begin
            w = next_rand();
            r = reg_addr_t'(i);
            if (i == 8) begin
                w[31] = 1'b1;
            end
            add_inst(imm_form(OP_LUI, REG_ZERO, r, w[31:16]));
            add_inst(imm_form(OP_ORI, r, r, w[15:0]));
        end
        // No write expected
        add_inst(imm_form(OP_ORI, 5'd1, REG_ZERO, rand16()));
        add_inst({6'b111111, 26'h2a5_c3e1});
        add_inst({OP_SPECIAL, 5'd1, 5'd2, 5'd3, 5'd0, 6'b111110});
        add_inst(imm_form(OP_ANDI, 5'd1, 5'd9, 16'h0000));
        add_inst(imm_form(OP_XORI, 5'd2, 5'd10, rand16()));
        add_inst(imm_form(OP_ANDI, 5'd10, 5'd11, rand16()));
        add_inst(imm_form(OP_LUI, 5'd11, 5'd12, rand16()));
        // Dependent chains hit every forward path
        add_inst(reg_form(F_OR, 5'd3, 5'd4, 5'd13));
        add_inst(reg_form(F_AND, 5'd13, 5'd5, 5'd14));
        add_inst(reg_form(F_XOR, 5'd13, 5'd14, 5'd15));
        add_inst(reg_form(F_NOR, 5'd13, 5'd15, 5'd16));
        add_inst(reg_form(F_SLLV, 5'd16, 5'd6, 5'd17));
        add_inst(reg_form(F_SRLV, 5'd17, 5'd8, 5'd18));
        add_inst(reg_form(F_SRAV, 5'd2, 5'd8, 5'd19));
        add_inst(reg_form(F_SRAV, 5'd18, 5'd17, 5'd20));
        add_inst(shamt_form(F_SLL, 5'd20, 5'd21, rand5()));
        add_inst(shamt_form(F_SRL, 5'd21, 5'd22, rand5()));
        add_inst(shamt_form(F_SRA, 5'd8, 5'd23, rand5()));
        add_inst(shamt_form(F_SRA, 5'd22, 5'd24, rand5()));
        // Conditional moves, r9 holds zero
        add_inst(reg_form(F_MOVN, 5'd1, 5'd2, 5'd25));
        add_inst(reg_form(F_MOVN, 5'd1, 5'd9, 5'd26));
        add_inst(reg_form(F_MOVZ, 5'd3, 5'd9, 5'd26));
        add_inst(reg_form(F_MOVZ, 5'd3, 5'd4, 5'd27));
        add_inst(imm_form(OP_ANDI, 5'd5, 5'd28, 16'h0000));
        add_inst(reg_form(F_MOVZ, 5'd6, 5'd28, 5'd27));
        add_inst(reg_form(F_MOVN, 5'd7, 5'd27, 5'd28));
        // HI/LO round trips
        add_inst(reg_form(F_MTHI, 5'd1, REG_ZERO, REG_ZERO));
        add_inst(reg_form(F_MFHI, REG_ZERO, REG_ZERO, 5'd29));
        add_inst(reg_form(F_MTLO, 5'd2, REG_ZERO, REG_ZERO));
        add_inst(reg_form(F_MFLO, REG_ZERO, REG_ZERO, 5'd30));
        add_inst(reg_form(F_MTHI, 5'd30, REG_ZERO, REG_ZERO));
        add_inst(reg_form(F_MTLO, 5'd29, REG_ZERO, REG_ZERO));
        add_inst(reg_form(F_MFHI, REG_ZERO, REG_ZERO, 5'd31));
        add_inst(reg_form(F_MFLO, REG_ZERO, REG_ZERO, 5'd1));
        add_inst(reg_form(F_OR, 5'd31, 5'd1, REG_ZERO));
    endtask

    task automatic check_wb(input string what, input reg_write_t got, input reg_write_t exp);
        logic bad;
        bad = (got.we !== exp.we);
        if (!bad && exp.we) begin
            bad = (got.addr !== exp.addr) || (got.data !== exp.data);
        end
        if (bad) begin
            $display("Fail at %0t: %s write-back we=%0b addr=%0d data=%h",
                     $time, what, got.we, got.addr, got.data);
            $display("    expected we=%0b addr=%0d data=%h", exp.we, exp.addr, exp.data);
            $display("Test failed");
            $fatal(1, "write-back mismatch");
        end
    endtask

    task automatic check_addr(input int cyc, input logic [INST_ADDR_W-1:0] got,
                              input logic [INST_ADDR_W-1:0] exp);
        if (got !== exp) begin
            $display("Fail at %0t: cycle %0d fetch address %h, expected %h",
                     $time, cyc, got, exp);
            $display("Test failed");
            $fatal(1, "fetch address mismatch");
        end
    endtask

    initial begin
        reset_i     = 1'b1;
        table_ready = 1'b0;
        build_program();
        table_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #(DRIVE_DELAY);
        reset_i = 1'b0;
        // Entry n is fetched in cycle n and written back in cycle n+3
        for (int c = 0; c < prog_len + 3; c++) begin
            @(negedge clk);
            check_addr(c, inst_addr, RESET_PC + INST_ADDR_W'(4 * c));
            if (c < 3) begin
                check_wb($sformatf("idle cycle %0d", c), debug_wb, '0);
            end else begin
                check_wb($sformatf("entry %0d", c - 3), debug_wb, prog_exp[c - 3]);
            end
        end
        $display("Test passed");
        $finish;
    end

    initial begin
        wait (table_ready);
        #((prog_len + 20) * CLK_PERIOD);
        $display("Watchdog timeout at %0t, the program did not finish", $time);
        $display("Test failed");
        $fatal(1, "watchdog timeout");
    end

endmodule

`default_nettype wire

/* hdl/mini_mips_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mini_mips_top import mips_core_pkg::*; #(
    parameter int unsigned            INST_ADDR_W = 32,
    parameter logic [INST_ADDR_W-1:0] RESET_PC    = '0
) (
    input  logic                   clk,
    input  logic                   reset_i,
    input  word_t                  inst_i,
    output logic [INST_ADDR_W-1:0] inst_addr_o,
    output reg_write_t             debug_wb_o
);

    word_t       id_inst;
    logic        rd1_en;
    logic        rd2_en;
    reg_addr_t   rd1_addr;
    reg_addr_t   rd2_addr;
    word_t       rd1_data;
    word_t       rd2_data;
    decode_out_t dec;
    reg_write_t  ex_fwd;
    reg_write_t  wb;

    fetch_stage #(
        .INST_ADDR_W (INST_ADDR_W),
        .RESET_PC    (RESET_PC)
    ) fetch0 (
        .clk         (clk),
        .reset_i     (reset_i),
        .inst_i      (inst_i),
        .inst_addr_o (inst_addr_o),
        .inst_o      (id_inst)
    );

    inst_decode decode0 (
        .inst_i     (id_inst),
        .rd1_data_i (rd1_data),
        .rd2_data_i (rd2_data),
        .ex_fwd_i   (ex_fwd),
        .wb_fwd_i   (wb),
        .rd1_en_o   (rd1_en),
        .rd2_en_o   (rd2_en),
        .rd1_addr_o (rd1_addr),
        .rd2_addr_o (rd2_addr),
        .dec_o      (dec)
    );

    reg_file regs0 (
        .clk        (clk),
        .reset_i    (reset_i),
        .wr_i       (wb),
        .rd1_en_i   (rd1_en),
        .rd2_en_i   (rd2_en),
        .rd1_addr_i (rd1_addr),
        .rd2_addr_i (rd2_addr),
        .rd1_data_o (rd1_data),
        .rd2_data_o (rd2_data)
    );

    execute exec0 (
        .clk      (clk),
        .reset_i  (reset_i),
        .dec_i    (dec),
        .ex_fwd_o (ex_fwd),
        .wb_o     (wb)
    );

    assign debug_wb_o = wb;

endmodule

`default_nettype wire

/* hdl/execute.sv */
`timescale 1ns/1ps
`default_nettype none

module execute import mips_core_pkg::*; (
    input  logic        clk,
    input  logic        reset_i,
    input  decode_out_t dec_i,
    output reg_write_t  ex_fwd_o,
    output reg_write_t  wb_o
);

    decode_out_t        dec_q;
    word_t              hi_q;
    word_t              lo_q;
    word_t              logic_res;
    word_t              shift_res;
    word_t              move_res;
    word_t              result;
    logic [SHAMT_W-1:0] shamt;
    reg_write_t         wb_q;

    // Decode/execute register
    always_ff @(posedge clk) begin
        if (reset_i) begin
            dec_q <= '0;
        end else begin
            dec_q <= dec_i;
        end
    end

    always_comb begin
        case (dec_q.aluop)
            ALU_OR:  logic_res = dec_q.op1 | dec_q.op2;
            ALU_AND: logic_res = dec_q.op1 & dec_q.op2;
            ALU_XOR: logic_res = dec_q.op1 ^ dec_q.op2;
            ALU_NOR: logic_res = ~(dec_q.op1 | dec_q.op2);
            default: logic_res = ZERO_WORD;
        endcase
    end

    // op1 holds the amount, op2 the value
    assign shamt = dec_q.op1[SHAMT_W-1:0];

    always_comb begin
        case (dec_q.aluop)
            ALU_SLL: shift_res = dec_q.op2 << shamt;
            ALU_SRL: shift_res = dec_q.op2 >> shamt;
            ALU_SRA: shift_res = word_t'($signed(dec_q.op2) >>> shamt);
            default: shift_res = ZERO_WORD;
        endcase
    end

    always_comb begin
        case (dec_q.aluop)
            ALU_MOVN, ALU_MOVZ: move_res = dec_q.op1;
            ALU_MFHI:           move_res = hi_q;
            ALU_MFLO:           move_res = lo_q;
            default:            move_res = ZERO_WORD;
        endcase
    end

    always_comb begin
        case (dec_q.alusel)
            SEL_LOGIC: result = logic_res;
            SEL_SHIFT: result = shift_res;
            SEL_MOVE:  result = move_res;
            default:   result = ZERO_WORD;
        endcase
    end

    // Visible to the next MFHI/MFLO in execute
    always_ff @(posedge clk) begin
        if (reset_i) begin
            hi_q <= ZERO_WORD;
            lo_q <= ZERO_WORD;
        end else if (dec_q.aluop == ALU_MTHI) begin
            hi_q <= dec_q.op1;
        end else if (dec_q.aluop == ALU_MTLO) begin
            lo_q <= dec_q.op1;
        end
    end

    always_comb begin
        ex_fwd_o.we   = dec_q.wreg;
        ex_fwd_o.addr = dec_q.wd;
        ex_fwd_o.data = result;
    end

    // Execute/writeback register
    always_ff @(posedge clk) begin
        if (reset_i) begin
            wb_q <= '0;
        end else begin
            wb_q <= ex_fwd_o;
        end
    end

    assign wb_o = wb_q;

endmodule

`default_nettype wire

/* hdl/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_file import mips_core_pkg::*; (
    input  logic       clk,
    input  logic       reset_i,
    input  reg_write_t wr_i,
    input  logic       rd1_en_i,
    input  logic       rd2_en_i,
    input  reg_addr_t  rd1_addr_i,
    input  reg_addr_t  rd2_addr_i,
    output word_t      rd1_data_o,
    output word_t      rd2_data_o
);

    // r0 has no storage
    word_t regs [1:NUM_REGS-1];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs[i] <= ZERO_WORD;
            end
        end else if (wr_i.we) begin
            regs[wr_i.addr] <= wr_i.data;
        end
    end

    function automatic word_t read_port(input logic en, input reg_addr_t addr);
        word_t val;
        if (!en || addr == REG_ZERO) begin
            val = ZERO_WORD;
        end else if (wr_i.we && wr_i.addr == addr) begin
            // Same-cycle write passes through
            val = wr_i.data;
        end else begin
            val = regs[addr];
        end
        return val;
    endfunction

    assign rd1_data_o = read_port(rd1_en_i, rd1_addr_i);
    assign rd2_data_o = read_port(rd2_en_i, rd2_addr_i);

endmodule

`default_nettype wire

/* hdl/inst_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module inst_decode import mips_core_pkg::*; (
    input  word_t       inst_i,
    input  word_t       rd1_data_i,
    input  word_t       rd2_data_i,
    input  reg_write_t  ex_fwd_i,
    input  reg_write_t  wb_fwd_i,
    output logic        rd1_en_o,
    output logic        rd2_en_o,
    output reg_addr_t   rd1_addr_o,
    output reg_addr_t   rd2_addr_o,
    output decode_out_t dec_o
);

    inst_t     inst;
    word_t     imm;
    alu_op_e   aluop;
    alu_sel_e  alusel;
    reg_addr_t wd;
    logic      wreg;
    logic      wreg_ok;
    word_t     op1;
    word_t     op2;

    // Execute result wins over writeback, then the register file
    function automatic word_t pick_operand(
        input logic       en,
        input reg_addr_t  addr,
        input word_t      rf_data,
        input reg_write_t ex_fwd,
        input reg_write_t wb_fwd,
        input word_t      imm_val
    );
        word_t val;
        if (!en) begin
            val = imm_val;
        end else if (ex_fwd.we && ex_fwd.addr == addr) begin
            val = ex_fwd.data;
        end else if (wb_fwd.we && wb_fwd.addr == addr) begin
            val = wb_fwd.data;
        end else begin
            val = rf_data;
        end
        return val;
    endfunction

    assign inst       = inst_i;
    assign rd1_addr_o = inst.rs;
    assign rd2_addr_o = inst.rt;

    always_comb begin
        aluop    = ALU_NOP;
        alusel   = SEL_NOP;
        wd       = inst.rd;
        wreg     = 1'b0;
        rd1_en_o = 1'b0;
        rd2_en_o = 1'b0;
        imm      = ZERO_WORD;
        case (inst.opcode)
            OP_SPECIAL: begin
                if (inst.shamt == '0) begin
                    // Register forms read rs and rt by default
                    rd1_en_o = 1'b1;
                    rd2_en_o = 1'b1;
                    wreg     = 1'b1;
                    case (inst.funct)
                        F_OR, F_AND, F_XOR, F_NOR: begin
                            alusel = SEL_LOGIC;
                            aluop  = (inst.funct == F_OR)  ? ALU_OR :
                                     (inst.funct == F_AND) ? ALU_AND :
                                     (inst.funct == F_XOR) ? ALU_XOR : ALU_NOR;
                        end
                        F_SLLV, F_SRLV, F_SRAV: begin
                            alusel = SEL_SHIFT;
                            aluop  = (inst.funct == F_SLLV) ? ALU_SLL :
                                     (inst.funct == F_SRLV) ? ALU_SRL : ALU_SRA;
                        end
                        F_MOVN, F_MOVZ: begin
                            alusel = SEL_MOVE;
                            aluop  = (inst.funct == F_MOVN) ? ALU_MOVN : ALU_MOVZ;
                        end
                        F_MFHI, F_MFLO: begin
                            alusel   = SEL_MOVE;
                            aluop    = (inst.funct == F_MFHI) ? ALU_MFHI : ALU_MFLO;
                            rd1_en_o = 1'b0;
                            rd2_en_o = 1'b0;
                        end
                        F_MTHI, F_MTLO: begin
                            aluop    = (inst.funct == F_MTHI) ? ALU_MTHI : ALU_MTLO;
                            rd2_en_o = 1'b0;
                            wreg     = 1'b0;
                        end
                        default: begin
                            rd1_en_o = 1'b0;
                            rd2_en_o = 1'b0;
                            wreg     = 1'b0;
                        end
                    endcase
                end
                // Immediate shifts, rs field is zero
                if (inst.rs == REG_ZERO &&
                    (inst.funct == F_SLL || inst.funct == F_SRL || inst.funct == F_SRA)) begin
                    alusel   = SEL_SHIFT;
                    aluop    = (inst.funct == F_SLL) ? ALU_SLL :
                               (inst.funct == F_SRL) ? ALU_SRL : ALU_SRA;
                    rd1_en_o = 1'b0;
                    rd2_en_o = 1'b1;
                    wreg     = 1'b1;
                    imm      = {{(WORD_W-SHAMT_W){1'b0}}, inst.shamt};
                end
            end
            OP_ORI, OP_ANDI, OP_XORI: begin
                alusel   = SEL_LOGIC;
                aluop    = (inst.opcode == OP_ORI)  ? ALU_OR :
                           (inst.opcode == OP_ANDI) ? ALU_AND : ALU_XOR;
                rd1_en_o = 1'b1;
                wreg     = 1'b1;
                wd       = inst.rt;
                imm      = {{(WORD_W-IMM_W){1'b0}}, inst_i[IMM_W-1:0]};
            end
            OP_LUI: begin
                alusel   = SEL_LOGIC;
                aluop    = ALU_OR;
                rd1_en_o = 1'b1;
                wreg     = 1'b1;
                wd       = inst.rt;
                imm      = {inst_i[IMM_W-1:0], {(WORD_W-IMM_W){1'b0}}};
            end
            default: begin
            end
        endcase
    end

    assign op1 = pick_operand(rd1_en_o, rd1_addr_o, rd1_data_i, ex_fwd_i, wb_fwd_i, imm);
    assign op2 = pick_operand(rd2_en_o, rd2_addr_o, rd2_data_i, ex_fwd_i, wb_fwd_i, imm);

    // Conditional moves depend on the resolved rt value
    always_comb begin
        wreg_ok = wreg;
        if (aluop == ALU_MOVN) begin
            wreg_ok = (op2 != ZERO_WORD);
        end else if (aluop == ALU_MOVZ) begin
            wreg_ok = (op2 == ZERO_WORD);
        end
        if (wd == REG_ZERO) begin
            wreg_ok = 1'b0;
        end
    end

    always_comb begin
        dec_o.aluop  = aluop;
        dec_o.alusel = alusel;
        dec_o.op1    = op1;
        dec_o.op2    = op2;
        dec_o.wd     = wd;
        dec_o.wreg   = wreg_ok;
    end

endmodule

`default_nettype wire

/* hdl/fetch_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_stage import mips_core_pkg::*; #(
    parameter int unsigned            INST_ADDR_W = 32,
    parameter logic [INST_ADDR_W-1:0] RESET_PC    = '0
) (
    input  logic                   clk,
    input  logic                   reset_i,
    input  word_t                  inst_i,
    output logic [INST_ADDR_W-1:0] inst_addr_o,
    output word_t                  inst_o
);

    logic [INST_ADDR_W-1:0] pc_q;
    word_t                  inst_q;

    // Fixed step, no stalls
    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc_q <= RESET_PC;
        end else begin
            pc_q <= pc_q + INST_ADDR_W'(4);
        end
    end

    // Fetch/decode register
    always_ff @(posedge clk) begin
        if (reset_i) begin
            inst_q <= ZERO_WORD;
        end else begin
            inst_q <= inst_i;
        end
    end

    assign inst_addr_o = pc_q;
    assign inst_o      = inst_q;

endmodule

`default_nettype wire

/* hdl/mips_core_pkg.sv */
`default_nettype none

package mips_core_pkg;

    localparam int WORD_W   = 32;
    localparam int REG_W    = 5;
    localparam int NUM_REGS = 32;
    localparam int IMM_W    = 16;
    localparam int SHAMT_W  = 5;

    typedef logic [REG_W-1:0]  reg_addr_t;
    typedef logic [WORD_W-1:0] word_t;

    localparam word_t     ZERO_WORD = '0;
    localparam reg_addr_t REG_ZERO  = '0;

    // Instruction fields, register format
    typedef struct packed {
        logic [5:0]         opcode;
        reg_addr_t          rs;
        reg_addr_t          rt;
        reg_addr_t          rd;
        logic [SHAMT_W-1:0] shamt;
        logic [5:0]         funct;
    } inst_t;

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'b000000,
        OP_ANDI    = 6'b001100,
        OP_ORI     = 6'b001101,
        OP_XORI    = 6'b001110,
        OP_LUI     = 6'b001111
    } opcode_e;

    typedef enum logic [5:0] {
        F_SLL  = 6'b000000,
        F_SRL  = 6'b000010,
        F_SRA  = 6'b000011,
        F_SLLV = 6'b000100,
        F_SRLV = 6'b000110,
        F_SRAV = 6'b000111,
        F_MOVZ = 6'b001010,
        F_MOVN = 6'b001011,
        F_MFHI = 6'b010000,
        F_MTHI = 6'b010001,
        F_MFLO = 6'b010010,
        F_MTLO = 6'b010011,
        F_AND  = 6'b100100,
        F_OR   = 6'b100101,
        F_XOR  = 6'b100110,
        F_NOR  = 6'b100111
    } funct_e;

    typedef enum logic [3:0] {
        ALU_NOP, ALU_OR, ALU_AND, ALU_XOR, ALU_NOR,
        ALU_SLL, ALU_SRL, ALU_SRA,
        ALU_MOVN, ALU_MOVZ, ALU_MFHI, ALU_MFLO, ALU_MTHI, ALU_MTLO
    } alu_op_e;

    typedef enum logic [1:0] {
        SEL_NOP, SEL_LOGIC, SEL_SHIFT, SEL_MOVE
    } alu_sel_e;

    typedef struct packed {
        alu_op_e   aluop;
        alu_sel_e  alusel;
        word_t     op1;
        word_t     op2;
        reg_addr_t wd;
        logic      wreg;
    } decode_out_t;

    typedef struct packed {
        logic      we;
        reg_addr_t addr;
        word_t     data;
    } reg_write_t;

endpackage

`default_nettype wire
